// ==== issue_pkg.sv ====
// Shared widths, instruction field positions and types for the issue stage; import where needed
package issue_pkg;

    // Datapath
    localparam int XLEN        = 32;
    localparam int INSTR_BYTES = 4;

    // Register file
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    // Low bits of the register fields in a 32-bit RISC-V instruction
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

// ==== pipe_status_if.sv ====
// Stage state of E1, E2 and WB, driven by the pipeline tracker and read by hazard, bypass and regfile
`timescale 1ns/1ps

interface pipe_status_if;
    import issue_pkg::*;

    // Destination index is zero for bubbles and for instructions without rd
    reg_idx_t rd_e1;
    logic     load_e1;
    reg_idx_t rd_e2;
    logic     load_e2;
    word_t    result_e2;
    reg_idx_t rd_wb;
    word_t    result_wb;

    modport tracker (
        output rd_e1, load_e1, rd_e2, load_e2, result_e2, rd_wb, result_wb
    );

    modport consumer (
        input rd_e1, load_e1, rd_e2, load_e2, result_e2, rd_wb, result_wb
    );

    modport writer (input rd_wb, result_wb);

endinterface

// ==== pc_tracker.sv ====
// Expected-PC register of the issue stage; flags fetch mismatches as redirects back to fetch
`timescale 1ns/1ps

module pc_tracker (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             fetch_valid_i,
    input  issue_pkg::word_t fetch_pc_i,
    input  logic             branch_exec_request_i,
    input  issue_pkg::word_t branch_exec_pc_i,
    input  logic             issue_i,
    output logic             candidate_o,
    output logic             branch_request_o,
    output issue_pkg::word_t branch_pc_o
);
    import issue_pkg::*;

    word_t expected_pc_q;
    logic  pc_match;

    // Compare word addresses only
    assign pc_match = fetch_pc_i[XLEN-1:$clog2(INSTR_BYTES)]
                   == expected_pc_q[XLEN-1:$clog2(INSTR_BYTES)];

    assign candidate_o      = fetch_valid_i & pc_match & ~branch_exec_request_i;
    assign branch_request_o = fetch_valid_i & ~pc_match & ~branch_exec_request_i;
    assign branch_pc_o      = expected_pc_q;

    // Execute redirect wins over sequential advance
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            expected_pc_q <= RESET_PC;
        else if (branch_exec_request_i)
            expected_pc_q <= branch_exec_pc_i;
        else if (issue_i)
            expected_pc_q <= expected_pc_q + word_t'(INSTR_BYTES);
    end

endmodule

// ==== pipe_tracker.sv ====
// Follows issued instructions through E1, E2 and WB and publishes their indices and results
`timescale 1ns/1ps

module pipe_tracker (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                issue_i,
    input  issue_pkg::reg_idx_t rd_idx_i,
    input  logic                rd_valid_i,
    input  logic                load_i,
    input  issue_pkg::word_t    alu_result_e1_i,
    input  issue_pkg::word_t    mem_result_e2_i,
    pipe_status_if.tracker      pipe_status
);
    import issue_pkg::*;

    reg_idx_t rd_e1_q;
    logic     load_e1_q;
    reg_idx_t rd_e2_q;
    logic     load_e2_q;
    reg_idx_t rd_wb_q;
    word_t    alu_e2_q;
    word_t    result_e2;
    word_t    result_wb_q;

    // Stages advance every cycle, a cycle without issue becomes a bubble
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_e1_q   <= '0;
            load_e1_q <= 1'b0;
            rd_e2_q   <= '0;
            load_e2_q <= 1'b0;
            rd_wb_q   <= '0;
        end
        else
        begin
            rd_e1_q   <= (issue_i && rd_valid_i) ? rd_idx_i : '0;
            load_e1_q <= issue_i & load_i;
            rd_e2_q   <= rd_e1_q;
            load_e2_q <= load_e1_q;
            rd_wb_q   <= rd_e2_q;
        end
    end

    always_ff @(posedge clk_i)
    begin
        alu_e2_q    <= alu_result_e1_i;
        result_wb_q <= result_e2;
    end

    // Load data arrives during E2
    assign result_e2 = load_e2_q ? mem_result_e2_i : alu_e2_q;

    assign pipe_status.rd_e1     = rd_e1_q;
    assign pipe_status.load_e1   = load_e1_q;
    assign pipe_status.rd_e2     = rd_e2_q;
    assign pipe_status.load_e2   = load_e2_q;
    assign pipe_status.result_e2 = result_e2;
    assign pipe_status.rd_wb     = rd_wb_q;
    assign pipe_status.result_wb = result_wb_q;

endmodule

// ==== hazard_scoreboard.sv ====
// Issue decision for the candidate instruction from the pending-load scoreboard and LSU stall
`timescale 1ns/1ps

module hazard_scoreboard #(
    parameter int LOAD_BYPASS = 1
) (
    input  logic                candidate_i,
    input  logic                lsu_stall_i,
    input  issue_pkg::reg_idx_t ra_idx_i,
    input  issue_pkg::reg_idx_t rb_idx_i,
    input  issue_pkg::reg_idx_t rd_idx_i,
    pipe_status_if.consumer     pipe_status,
    output logic                issue_o
);
    import issue_pkg::*;

    logic [NUM_REGS-1:0] busy;
    logic                hazard;

    always_comb
    begin
        busy = '0;
        // Load data is not ready while the load sits in E1
        if (pipe_status.load_e1)
            busy[pipe_status.rd_e1] = 1'b1;
        // Without load bypass the result is only usable from WB
        if (LOAD_BYPASS == 0 && pipe_status.load_e2)
            busy[pipe_status.rd_e2] = 1'b1;
        busy[0] = 1'b0;
    end

    assign hazard  = busy[ra_idx_i] | busy[rb_idx_i] | busy[rd_idx_i];
    assign issue_o = candidate_i & ~lsu_stall_i & ~hazard;

endmodule

// ==== regfile.sv ====
// Integer register file, 32 by 32, two asynchronous read ports and the WB write port
`timescale 1ns/1ps

module regfile (
    input  logic                clk_i,
    input  logic                rst_i,
    input  issue_pkg::reg_idx_t ra_idx_i,
    input  issue_pkg::reg_idx_t rb_idx_i,
    pipe_status_if.writer       pipe_status,
    output issue_pkg::word_t    ra_value_o,
    output issue_pkg::word_t    rb_value_o
);
    import issue_pkg::*;

    word_t regs_q [NUM_REGS];

    // x0 is never written so it keeps its reset value
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (pipe_status.rd_wb != '0)
        begin
            regs_q[pipe_status.rd_wb] <= pipe_status.result_wb;
        end
    end

    assign ra_value_o = regs_q[ra_idx_i];
    assign rb_value_o = regs_q[rb_idx_i];

endmodule

// ==== operand_bypass.sv ====
// Source operand forwarding from E1, E2 and WB ahead of the register file value
`timescale 1ns/1ps

module operand_bypass (
    input  issue_pkg::reg_idx_t ra_idx_i,
    input  issue_pkg::reg_idx_t rb_idx_i,
    input  issue_pkg::word_t    ra_file_i,
    input  issue_pkg::word_t    rb_file_i,
    input  issue_pkg::word_t    alu_result_e1_i,
    pipe_status_if.consumer     pipe_status,
    output issue_pkg::word_t    ra_operand_o,
    output issue_pkg::word_t    rb_operand_o
);
    import issue_pkg::*;

    // Newest in-flight producer wins
    function automatic word_t select_operand(input reg_idx_t idx, input word_t file_value);
        word_t value;
        if (idx == '0)
            value = '0;
        else if (pipe_status.rd_e1 == idx)
            value = alu_result_e1_i;
        else if (pipe_status.rd_e2 == idx)
            value = pipe_status.result_e2;
        else if (pipe_status.rd_wb == idx)
            value = pipe_status.result_wb;
        else
            value = file_value;
        return value;
    endfunction

    assign ra_operand_o = select_operand(ra_idx_i, ra_file_i);
    assign rb_operand_o = select_operand(rb_idx_i, rb_file_i);

endmodule

// ==== issue_stage.sv ====
// Single-issue in-order issue stage top level; connect fetch, execute and the issue port here
`timescale 1ns/1ps

module issue_stage (
    input  logic               clk_i,
    input  logic               rst_i,

    input  logic               fetch_valid_i,
    input  issue_pkg::word_t   fetch_instr_i,
    input  issue_pkg::word_t   fetch_pc_i,
    input  logic               fetch_load_i,
    input  logic               fetch_rd_valid_i,
    output logic               fetch_accept_o,

    output logic               branch_request_o,
    output issue_pkg::word_t   branch_pc_o,

    input  logic               branch_exec_request_i,
    input  issue_pkg::word_t   branch_exec_pc_i,
    input  issue_pkg::word_t   alu_result_e1_i,
    input  issue_pkg::word_t   mem_result_e2_i,
    input  logic               lsu_stall_i,

    output logic               issue_valid_o,
    output issue_pkg::word_t   issue_opcode_o,
    output issue_pkg::word_t   issue_pc_o,
    output issue_pkg::reg_idx_t issue_rd_o,
    output issue_pkg::word_t   issue_ra_operand_o,
    output issue_pkg::word_t   issue_rb_operand_o
);
    import issue_pkg::*;

    reg_idx_t rd_idx;
    reg_idx_t ra_idx;
    reg_idx_t rb_idx;
    logic     candidate;
    logic     issue;
    word_t    ra_file;
    word_t    rb_file;

    pipe_status_if pipe_status ();

    assign rd_idx = fetch_instr_i[RD_LSB +: REG_IDX_W];
    assign ra_idx = fetch_instr_i[RS1_LSB +: REG_IDX_W];
    assign rb_idx = fetch_instr_i[RS2_LSB +: REG_IDX_W];

    pc_tracker pc_tracker_i (
        .clk_i                 (clk_i),
        .rst_i                 (rst_i),
        .fetch_valid_i         (fetch_valid_i),
        .fetch_pc_i            (fetch_pc_i),
        .branch_exec_request_i (branch_exec_request_i),
        .branch_exec_pc_i      (branch_exec_pc_i),
        .issue_i               (issue),
        .candidate_o           (candidate),
        .branch_request_o      (branch_request_o),
        .branch_pc_o           (branch_pc_o)
    );

    hazard_scoreboard #(
        .LOAD_BYPASS (1)
    ) hazard_scoreboard_i (
        .candidate_i (candidate),
        .lsu_stall_i (lsu_stall_i),
        .ra_idx_i    (ra_idx),
        .rb_idx_i    (rb_idx),
        .rd_idx_i    (rd_idx),
        .pipe_status (pipe_status.consumer),
        .issue_o     (issue)
    );

    pipe_tracker pipe_tracker_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .issue_i         (issue),
        .rd_idx_i        (rd_idx),
        .rd_valid_i      (fetch_rd_valid_i),
        .load_i          (fetch_load_i),
        .alu_result_e1_i (alu_result_e1_i),
        .mem_result_e2_i (mem_result_e2_i),
        .pipe_status     (pipe_status.tracker)
    );

    regfile regfile_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ra_idx_i    (ra_idx),
        .rb_idx_i    (rb_idx),
        .pipe_status (pipe_status.writer),
        .ra_value_o  (ra_file),
        .rb_value_o  (rb_file)
    );

    operand_bypass operand_bypass_i (
        .ra_idx_i        (ra_idx),
        .rb_idx_i        (rb_idx),
        .ra_file_i       (ra_file),
        .rb_file_i       (rb_file),
        .alu_result_e1_i (alu_result_e1_i),
        .pipe_status     (pipe_status.consumer),
        .ra_operand_o    (issue_ra_operand_o),
        .rb_operand_o    (issue_rb_operand_o)
    );

    // Fetch is accepted exactly when the instruction issues
    assign issue_valid_o  = issue;
    assign fetch_accept_o = issue;
    assign issue_opcode_o = fetch_instr_i;
    assign issue_pc_o     = fetch_pc_i;
    assign issue_rd_o     = rd_idx;

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and power-on reset source; instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD_NS = 5;
    localparam int RESET_CYCLES   = 2;

    initial
    begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Release reset just after a rising edge
    initial
    begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// ==== issue_stage_chk.sv ====
// Port protocol assertions for the issue stage; bound into issue_stage by the testbench top
`timescale 1ns/1ps

module issue_stage_chk (
    input logic clk_i,
    input logic rst_i,
    input logic fetch_valid_i,
    input logic fetch_accept_i,
    input logic branch_request_i,
    input logic issue_valid_i,
    input logic lsu_stall_i
);
    int unsigned violation_count = 0;

    // A redirect cycle never accepts the fetched instruction
    redirect_excludes_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        !(branch_request_i && fetch_accept_i))
    else
    begin
        $error("branch request and fetch accept are high in the same cycle");
        violation_count++;
    end

    issue_needs_fetch: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_valid_i |-> fetch_valid_i)
    else
    begin
        $error("issue valid without a valid fetch");
        violation_count++;
    end

    no_issue_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_stall_i |-> !issue_valid_i)
    else
    begin
        $error("instruction issued while the LSU stalls");
        violation_count++;
    end

endmodule

// ==== issue_stage_tb.sv ====
// Testbench top for the issue stage; replays the golden vectors cycle by cycle and checks outputs
`timescale 1ns/1ps

module issue_stage_tb;
    import issue_pkg::*;

    localparam int NUM_FIELDS   = 17;
    localparam int EXTRA_CYCLES = 20;
    // Column order of one golden line
    localparam int COL_FETCH_VALID = 0;
    localparam int COL_INSTR       = 1;
    localparam int COL_PC          = 2;
    localparam int COL_LOAD        = 3;
    localparam int COL_RD_VALID    = 4;
    localparam int COL_BX_REQ      = 5;
    localparam int COL_BX_PC       = 6;
    localparam int COL_ALU_E1      = 7;
    localparam int COL_MEM_E2      = 8;
    localparam int COL_STALL       = 9;
    localparam int COL_EXP_ACCEPT  = 10;
    localparam int COL_EXP_BREQ    = 11;
    localparam int COL_EXP_BPC     = 12;
    localparam int COL_EXP_VALID   = 13;
    localparam int COL_EXP_RD      = 14;
    localparam int COL_EXP_RA      = 15;
    localparam int COL_EXP_RB      = 16;

    logic     clk;
    logic     rst;
    logic     fetch_valid;
    word_t    fetch_instr;
    word_t    fetch_pc;
    logic     fetch_load;
    logic     fetch_rd_valid;
    logic     fetch_accept;
    logic     branch_request;
    word_t    branch_pc;
    logic     branch_exec_request;
    word_t    branch_exec_pc;
    word_t    alu_result_e1;
    word_t    mem_result_e2;
    logic     lsu_stall;
    logic     issue_valid;
    word_t    issue_opcode;
    word_t    issue_pc;
    reg_idx_t issue_rd;
    word_t    issue_ra_operand;
    word_t    issue_rb_operand;

    word_t vectors [$];
    int    num_vectors = 0;
    int    cycle_limit = EXTRA_CYCLES;
    int    cycle_count = 0;
    int    check_count = 0;
    int    error_count = 0;
    bit    load_ok     = 1'b0;

    tb_clock_gen clock_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    issue_stage issue_stage_i (
        .clk_i                 (clk),
        .rst_i                 (rst),
        .fetch_valid_i         (fetch_valid),
        .fetch_instr_i         (fetch_instr),
        .fetch_pc_i            (fetch_pc),
        .fetch_load_i          (fetch_load),
        .fetch_rd_valid_i      (fetch_rd_valid),
        .fetch_accept_o        (fetch_accept),
        .branch_request_o      (branch_request),
        .branch_pc_o           (branch_pc),
        .branch_exec_request_i (branch_exec_request),
        .branch_exec_pc_i      (branch_exec_pc),
        .alu_result_e1_i       (alu_result_e1),
        .mem_result_e2_i       (mem_result_e2),
        .lsu_stall_i           (lsu_stall),
        .issue_valid_o         (issue_valid),
        .issue_opcode_o        (issue_opcode),
        .issue_pc_o            (issue_pc),
        .issue_rd_o            (issue_rd),
        .issue_ra_operand_o    (issue_ra_operand),
        .issue_rb_operand_o    (issue_rb_operand)
    );

    bind issue_stage issue_stage_chk issue_stage_chk_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_accept_i   (fetch_accept_o),
        .branch_request_i (branch_request_o),
        .issue_valid_i    (issue_valid_o),
        .lsu_stall_i      (lsu_stall_i)
    );

    function automatic word_t vector_field(input int row, input int col);
        return vectors[row * NUM_FIELDS + col];
    endfunction

    task automatic load_vectors();
        int    fd;
        int    count;
        string line;
        word_t f [NUM_FIELDS];
        fd = $fopen("issue_golden.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the golden vector file");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 0 && line[0] != "#")
                begin
                    count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                    if (count == NUM_FIELDS)
                    begin
                        for (int i = 0; i < NUM_FIELDS; i++)
                            vectors.push_back(f[i]);
                        num_vectors++;
                    end
                    else if (count > 0)
                    begin
                        $display("Malformed line in the golden vector file: %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            if (num_vectors == 0)
                $display("The golden vector file holds no vectors");
            load_ok = (num_vectors > 0);
        end
    endtask

    task automatic drive_inputs(input int row);
        fetch_valid         = vector_field(row, COL_FETCH_VALID) != '0;
        fetch_instr         = vector_field(row, COL_INSTR);
        fetch_pc            = vector_field(row, COL_PC);
        fetch_load          = vector_field(row, COL_LOAD) != '0;
        fetch_rd_valid      = vector_field(row, COL_RD_VALID) != '0;
        branch_exec_request = vector_field(row, COL_BX_REQ) != '0;
        branch_exec_pc      = vector_field(row, COL_BX_PC);
        alu_result_e1       = vector_field(row, COL_ALU_E1);
        mem_result_e2       = vector_field(row, COL_MEM_E2);
        lsu_stall           = vector_field(row, COL_STALL) != '0;
    endtask

    task automatic report_mismatch(input int row, input string name,
                                   input word_t actual, input word_t expected);
        $display("Error: vector %0d %s = %h, expected %h", row, name, actual, expected);
        error_count++;
    endtask

    task automatic check_outputs(input int row);
        logic exp_accept;
        logic exp_breq;
        logic exp_valid;
        exp_accept = vector_field(row, COL_EXP_ACCEPT) != '0;
        exp_breq   = vector_field(row, COL_EXP_BREQ) != '0;
        exp_valid  = vector_field(row, COL_EXP_VALID) != '0;
        check_count++;
        if (fetch_accept !== exp_accept)
            report_mismatch(row, "fetch_accept_o", word_t'(fetch_accept), word_t'(exp_accept));
        if (branch_request !== exp_breq)
            report_mismatch(row, "branch_request_o", word_t'(branch_request), word_t'(exp_breq));
        if (issue_valid !== exp_valid)
            report_mismatch(row, "issue_valid_o", word_t'(issue_valid), word_t'(exp_valid));
        if (exp_breq && branch_pc !== vector_field(row, COL_EXP_BPC))
            report_mismatch(row, "branch_pc_o", branch_pc, vector_field(row, COL_EXP_BPC));
        // Payload only matters for an issued instruction
        if (exp_valid && issue_opcode !== vector_field(row, COL_INSTR))
            report_mismatch(row, "issue_opcode_o", issue_opcode, vector_field(row, COL_INSTR));
        if (exp_valid && issue_pc !== vector_field(row, COL_PC))
            report_mismatch(row, "issue_pc_o", issue_pc, vector_field(row, COL_PC));
        if (exp_valid && word_t'(issue_rd) !== vector_field(row, COL_EXP_RD))
            report_mismatch(row, "issue_rd_o", word_t'(issue_rd), vector_field(row, COL_EXP_RD));
        if (exp_valid && issue_ra_operand !== vector_field(row, COL_EXP_RA))
            report_mismatch(row, "issue_ra_operand_o", issue_ra_operand,
                            vector_field(row, COL_EXP_RA));
        if (exp_valid && issue_rb_operand !== vector_field(row, COL_EXP_RB))
            report_mismatch(row, "issue_rb_operand_o", issue_rb_operand,
                            vector_field(row, COL_EXP_RB));
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial
    begin
        fetch_valid         = 1'b0;
        fetch_instr         = '0;
        fetch_pc            = '0;
        fetch_load          = 1'b0;
        fetch_rd_valid      = 1'b0;
        branch_exec_request = 1'b0;
        branch_exec_pc      = '0;
        alu_result_e1       = '0;
        mem_result_e2       = '0;
        lsu_stall           = 1'b0;
        load_vectors();
        cycle_limit = num_vectors + EXTRA_CYCLES;
        if (!load_ok)
        begin
            $display("Test failures found");
            $finish;
        end
        else
        begin
            // Reset falls 1 ns after an edge, the drive point of the first vector
            wait (rst == 1'b0);
            for (int row = 0; row < num_vectors; row++)
            begin
                drive_inputs(row);
                #8;
                check_outputs(row);
                @(posedge clk);
                #1;
            end
            $display("Vectors: %0d, errors: %0d, assertion failures: %0d", check_count,
                     error_count, issue_stage_i.issue_stage_chk_i.violation_count);
            if (error_count == 0 && issue_stage_i.issue_stage_chk_i.violation_count == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
    end

endmodule

// ==== issue_golden.txt ====
# in:  fetch_valid instr pc load rd_valid bx_req bx_pc alu_e1 mem_e2 lsu_stall
# exp: fetch_accept branch_req branch_pc issue_valid rd ra_operand rb_operand (all hex)
0 00000000 000 0 0 0 000 00000000 00000000 0 0 0 000 0 00 00000000 00000000
1 000000B3 000 0 1 0 000 00000000 00000000 0 1 0 000 1 01 00000000 00000000
1 00008133 004 0 1 0 000 11111111 00000000 0 1 0 000 1 02 11111111 00000000
1 002081B3 008 0 1 0 000 22222222 00000000 0 1 0 000 1 03 11111111 22222222
1 00308233 00C 0 1 0 000 33333333 00000000 0 1 0 000 1 04 11111111 33333333
1 00000013 040 0 1 0 000 44444444 00000000 0 0 1 010 0 00 00000000 00000000
1 002082B3 010 0 1 0 000 00000000 00000000 0 1 0 000 1 05 11111111 22222222
1 00000013 014 0 1 1 100 55555555 00000000 0 0 0 000 0 00 00000000 00000000
1 00008303 100 1 1 0 000 00000000 00000000 0 1 0 000 1 06 11111111 00000000
1 006083B3 104 0 1 0 000 00000200 00000000 0 0 0 000 0 00 00000000 00000000
1 006083B3 104 0 1 0 000 00000000 66666666 0 1 0 000 1 07 11111111 66666666
1 007003B3 108 0 1 0 000 77777777 00000000 0 1 0 000 1 07 00000000 77777777
1 00708433 10C 0 1 0 000 7777AAAA 00000000 0 1 0 000 1 08 11111111 7777AAAA
1 00600033 110 0 1 0 000 88888888 00000000 0 1 0 000 1 00 00000000 66666666
1 000004B3 114 0 1 0 000 DEADBEEF 00000000 1 0 0 000 0 00 00000000 00000000
1 000004B3 114 0 1 0 000 00000000 00000000 1 0 0 000 0 00 00000000 00000000
1 000004B3 114 0 1 0 000 00000000 00000000 0 1 0 000 1 09 00000000 00000000
1 00800533 118 0 1 0 000 99999999 00000000 0 1 0 000 1 0A 00000000 88888888
0 00000000 000 0 0 0 000 AAAAAAAA 00000000 0 0 0 000 0 00 00000000 00000000
0 00000000 000 0 0 0 000 00000000 00000000 0 0 0 000 0 00 00000000 00000000

// ==== all.f ====
issue_pkg.sv
pipe_status_if.sv
pc_tracker.sv
pipe_tracker.sv
hazard_scoreboard.sv
regfile.sv
operand_bypass.sv
issue_stage.sv
tb_clock_gen.sv
issue_stage_chk.sv
issue_stage_tb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - issue_pkg.sv
  - pipe_status_if.sv
  - pc_tracker.sv
  - pipe_tracker.sv
  - hazard_scoreboard.sv
  - regfile.sv
  - operand_bypass.sv
  - issue_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - issue_stage_chk.sv
      - issue_stage_tb.sv
